/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_uart_link
FILELIST = uart_link.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     = $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "simulation clean, log in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_uart_link.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_link_settings.svh"

module tb_uart_link import uart_cmd_pkg::*; ();

  // upper bound on bytes on the line, responses included
  localparam int     BYTES_SENT  = 120;
  localparam longint DIV_MAX     = longint'(`BAUD_DIV_RST) + 256;  // covers the setup frames
  localparam longint WATCHDOG_NS = BYTES_SENT * 12 * DIV_MAX * 4 + 100000;

  logic       sys_clk;
  logic       arst_n;
  logic       uart_rxd;
  wire        uart_txd;
  wire  [7:0] rx_data;
  wire        rx_strobe;

  // reference model of the register block
  logic [`BAUD_DIV_W-1:0] m_div;
  logic [7:0]             m_scratch0;
  logic [7:0]             m_scratch1;
  logic [7:0]             m_err;
  logic [7:0]             m_addr;
  dec_state_e             m_state;
  cmd_op_e                m_op;
  longint                 busy_end = 0;   // model estimate of tx_busy falling
  longint                 cyc = 0;
  logic [7:0]             exp_rx_q[$];    // bytes the receiver should strobe
  logic [7:0]             exp_tx_q[$];    // read responses still due
  int                     errors = 0;
  int                     checks = 0;

  uart_link_top uart_link_top_inst (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .uart_rxd  (uart_rxd),
    .uart_txd  (uart_txd),
    .rx_data   (rx_data),
    .rx_strobe (rx_strobe)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;  // 4 ns period
  end

  always @(posedge sys_clk) cyc <= cyc + 1;

  //**************************************************
  // compare tasks
  //**************************************************

  task automatic check_rx_byte(input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: rx_data %02h, expected %02h", $time, got, exp);
    end
  endtask

  task automatic check_reg_byte(input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: response byte %02h, expected %02h", $time, got, exp);
    end
  endtask

  //**************************************************
  // reference model
  //**************************************************

  function automatic void bump_err();
    if (m_err != 8'hff) m_err = m_err + 8'd1;  // saturates
  endfunction

  function automatic logic [7:0] reg_value(input logic [7:0] addr);
    case (addr)
      `REG_DIV_LO:   return m_div[7:0];
      `REG_DIV_HI:   return m_div[15:8];
      `REG_SCRATCH0: return m_scratch0;
      `REG_SCRATCH1: return m_scratch1;
      default:       return m_err;
    endcase
  endfunction

  function automatic void write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [`BAUD_DIV_W-1:0] div_try;
    div_try = m_div;
    case (addr)
      `REG_DIV_LO:   div_try[7:0] = data;   // one byte replaced
      `REG_DIV_HI:   div_try[15:8] = data;
      `REG_SCRATCH0: m_scratch0 = data;
      `REG_SCRATCH1: m_scratch1 = data;
      default:       m_err = 8'd0;          // error counter clears
    endcase
    if (div_try >= `BAUD_DIV_MIN) m_div = div_try;  // too small, old value stays
  endfunction

  // one received byte through the frame decoder
  task automatic model_byte(input logic [7:0] b, input bit stop_ok, input longint start_cyc);
    longint strobe_cyc;
    // sync delay plus nine and a half bits
    strobe_cyc = start_cyc + 2 + 9 * m_div + m_div / 2;
    if (!stop_ok) begin
      bump_err();
      m_state = DEC_OP;
    end else begin
      case (m_state)
        DEC_OP: begin
          if (b == CMD_WRITE || b == CMD_READ) begin
            m_op    = cmd_op_e'(b);
            m_state = DEC_ADDR;
          end else begin
            bump_err();                     // unknown opcode dropped
          end
        end
        DEC_ADDR: begin
          m_state = DEC_OP;
          if (b > `REG_ERR_CNT) begin
            bump_err();
          end else if (m_op == CMD_WRITE) begin
            m_addr  = b;
            m_state = DEC_DATA;
          end else if (strobe_cyc < busy_end) begin
            bump_err();                     // transmitter still busy
          end else begin
            exp_tx_q.push_back(reg_value(b));
            busy_end = strobe_cyc + 2 + 10 * m_div;
          end
        end
        default: begin
          write_reg(m_addr, b);
          m_state = DEC_OP;
        end
      endcase
    end
  endtask

  //**************************************************
  // serial driver and monitors
  //**************************************************

  task automatic drive_byte(input logic [7:0] b, input bit stop_ok);
    longint start_cyc;
    if (stop_ok) exp_rx_q.push_back(b);
    @(negedge sys_clk);
    start_cyc = cyc;
    uart_rxd  = 1'b0;                       // start bit
    repeat (m_div) @(negedge sys_clk);
    for (int i = 0; i < 8; i++) begin
      uart_rxd = b[i];                      // lsb first
      repeat (m_div) @(negedge sys_clk);
    end
    uart_rxd = stop_ok;
    repeat (m_div) @(negedge sys_clk);
    uart_rxd = 1'b1;
    if (!stop_ok) repeat (m_div) @(negedge sys_clk);  // idle before next start
    model_byte(b, stop_ok, start_cyc);
  endtask

  task automatic send_write(input logic [7:0] addr, input logic [7:0] data);
    drive_byte(CMD_WRITE, 1'b1);
    drive_byte(addr, 1'b1);
    drive_byte(data, 1'b1);
  endtask

  task automatic send_read(input logic [7:0] addr);
    drive_byte(CMD_READ, 1'b1);
    drive_byte(addr, 1'b1);
  endtask

  // wait until every expected byte was seen, bounded
  task automatic wait_drain();
    int n;
    int limit;
    n     = 0;
    limit = 40 * m_div + 200;
    while ((exp_rx_q.size() != 0 || exp_tx_q.size() != 0 || cyc < busy_end) && n < limit) begin
      @(negedge sys_clk);
      n++;
    end
    if (n >= limit) begin
      errors++;
      $display("gave up waiting at %0t: %0d received and %0d response bytes never appeared",
               $time, exp_rx_q.size(), exp_tx_q.size());
      exp_rx_q.delete();
      exp_tx_q.delete();
    end
    repeat (4) @(negedge sys_clk);
  endtask

  always @(negedge sys_clk) begin
    if (arst_n && rx_strobe) begin
      if (exp_rx_q.size() == 0) begin
        errors++;
        $display("rx_strobe at %0t with no byte outstanding", $time);
      end else begin
        check_rx_byte(rx_data, exp_rx_q.pop_front());
      end
    end
  end

  initial begin : tx_monitor
    logic [7:0]             got;
    logic [`BAUD_DIV_W-1:0] div;
    @(posedge arst_n);
    forever begin
      @(negedge sys_clk);
      if (uart_txd === 1'b0) begin
        div = m_div;
        repeat (div / 2) @(negedge sys_clk);  // middle of start bit
        if (uart_txd !== 1'b0) begin
          errors++;
          $display("uart_txd start bit too short at %0t", $time);
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (div) @(negedge sys_clk);
            got[i] = uart_txd;
          end
          repeat (div) @(negedge sys_clk);
          if (uart_txd !== 1'b1) begin
            errors++;
            $display("uart_txd stop bit low at %0t", $time);
          end else if (exp_tx_q.size() == 0) begin
            errors++;
            $display("unexpected response byte %02h at %0t", got, $time);
          end else begin
            check_reg_byte(got, exp_tx_q.pop_front());
          end
        end
      end
    end
  end

  //**************************************************
  // tests
  //**************************************************

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) $display("test %0d %s: ok", num, name);
    else $display("test %0d %s: %0d mismatches", num, name, errors - errs_before);
  endtask

  initial begin : main
    logic [7:0] b;
    logic [7:0] v0;
    logic [7:0] v1;
    int         errs_before;
    arst_n     = 1'b0;
    uart_rxd   = 1'b1;                      // idle line
    m_div      = `BAUD_DIV_RST;
    m_scratch0 = 8'd0;
    m_scratch1 = 8'd0;
    m_err      = 8'd0;
    m_addr     = 8'd0;
    m_state    = DEC_OP;
    m_op       = CMD_WRITE;
    void'($urandom(42091));
    repeat (4) @(negedge sys_clk);
    arst_n = 1'b1;

    // drop to divisor 16, low byte first
    send_write(`REG_DIV_LO, 8'd16);
    send_write(`REG_DIV_HI, 8'd0);
    wait_drain();
    $display("setup: divisor now %0d", m_div);

    errs_before = errors;
    repeat (32) begin
      b = 8'($urandom);
      while (b == CMD_WRITE || b == CMD_READ) b = 8'($urandom);  // keep the rate fixed
      drive_byte(b, 1'b1);
    end
    wait_drain();
    report_test(1, "random bytes on rx_data", errs_before);

    errs_before = errors;
    v0 = 8'($urandom);
    v1 = 8'($urandom);
    send_write(`REG_SCRATCH0, v0);
    send_write(`REG_SCRATCH1, v1);
    send_read(`REG_SCRATCH0);
    send_read(`REG_SCRATCH1);
    wait_drain();
    report_test(2, "scratch write and read", errs_before);

    errs_before = errors;
    send_write(`REG_DIV_LO, 8'd24);
    wait_drain();
    send_read(`REG_DIV_LO);
    send_read(`REG_DIV_HI);
    v0 = 8'($urandom);
    send_write(`REG_SCRATCH0, v0);
    send_read(`REG_SCRATCH0);
    wait_drain();
    send_write(`REG_DIV_LO, 8'd4);          // below minimum
    send_read(`REG_DIV_LO);
    send_read(`REG_DIV_HI);
    wait_drain();
    report_test(3, "divisor change", errs_before);

    errs_before = errors;
    send_write(`REG_ERR_CNT, 8'd0);
    drive_byte(8'h00, 1'b1);                // unknown opcodes
    drive_byte(8'ha5, 1'b1);
    drive_byte(8'h77, 1'b1);
    send_read(8'd9);                        // bad addresses
    drive_byte(CMD_WRITE, 1'b1);
    drive_byte(8'd7, 1'b1);
    drive_byte(8'h3c, 1'b0);                // stop bit low
    send_read(`REG_ERR_CNT);
    wait_drain();
    send_write(`REG_ERR_CNT, 8'h5a);
    send_read(`REG_ERR_CNT);
    wait_drain();
    report_test(4, "error counter", errs_before);

    // reads back to back, model decides on drops
    errs_before = errors;
    v0 = m_err;
    send_read(`REG_SCRATCH1);
    send_read(`REG_SCRATCH0);
    send_read(`REG_ERR_CNT);
    wait_drain();
    $display("test 5 model dropped %0d reads", m_err - v0);
    report_test(5, "reads during response", errs_before);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* uart_cmd_pkg.sv */
`default_nettype none

// command-level types for the byte protocol on top of the line
package uart_cmd_pkg;

  // opcode byte, first byte of every frame
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h57,  // ascii W, op addr data
    CMD_READ  = 8'h52   // ascii R, op addr
  } cmd_op_e;

  // decoder position inside a frame
  typedef enum logic [1:0] {
    DEC_OP   = 2'd0,  // expect opcode
    DEC_ADDR = 2'd1,  // expect register address
    DEC_DATA = 2'd2   // expect write data
  } dec_state_e;

  // any byte other than the two opcodes is an error
  // frames never nest, a new opcode is only taken in DEC_OP
  // a read ends in DEC_ADDR, a write in DEC_DATA

endpackage

`default_nettype wire

/* uart_line_pkg.sv */
`default_nettype none

// line-level types shared by the serial receiver and transmitter
package uart_line_pkg;

  // receiver FSM, one state per frame section
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,  // waiting for a falling edge
    RX_START = 2'd1,  // start bit, rechecked at mid-bit
    RX_DATA  = 2'd2,  // 8 data bits, lsb first
    RX_STOP  = 2'd3   // stop bit checked at mid-bit
  } rx_state_e;

  // transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,  // line held high
    TX_START = 2'd1,  // line low for one bit
    TX_DATA  = 2'd2,  // shifting out the latched byte
    TX_STOP  = 2'd3   // line high for one bit, still busy
  } tx_state_e;

endpackage

`default_nettype wire

/* uart_link.f */
+incdir+.
uart_line_pkg.sv
uart_cmd_pkg.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_link_top.sv
tb_uart_link.sv

/* uart_link_settings.svh */
`ifndef UART_LINK_SETTINGS_SVH
`define UART_LINK_SETTINGS_SVH

//**************************************************
// clocking and line rate
//**************************************************

// audio-style system clock
`define CLK_FREQ       49152000
`define UART_BPS       9600

// divisor in sys_clk cycles per bit
`define BAUD_DIV_W     16
`define BAUD_DIV_RST   16'(`CLK_FREQ / `UART_BPS)
`define BAUD_DIV_MIN   16'd8   // need a few cycles for a usable mid-bit sample

//**************************************************
// register map, byte addresses
//**************************************************

`define REG_DIV_LO     8'd0    // divisor bits 7..0
`define REG_DIV_HI     8'd1    // divisor bits 15..8
`define REG_SCRATCH0   8'd2
`define REG_SCRATCH1   8'd3
`define REG_ERR_CNT    8'd4    // write of any value clears

`endif

/* uart_link_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_link_settings.svh"

module uart_link_top (
  input  wire        sys_clk,
  input  wire        arst_n,
  input  wire        uart_rxd,
  output logic       uart_txd,
  output logic [7:0] rx_data,    // observation of received byte
  output logic       rx_strobe
);

  logic [`BAUD_DIV_W-1:0] baud_div;  // from register block
  logic                   rx_frame_err;
  logic [7:0]             tx_data;
  logic                   tx_start;
  logic                   tx_busy;

  //**************************************************
  // line side
  //**************************************************

  uart_rx uart_rx_inst (
    .sys_clk      (sys_clk),
    .arst_n       (arst_n),
    .uart_rxd     (uart_rxd),
    .baud_div     (baud_div),
    .rx_data      (rx_data),
    .rx_strobe    (rx_strobe),
    .rx_frame_err (rx_frame_err)
  );

  uart_tx uart_tx_inst (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .baud_div (baud_div),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .uart_txd (uart_txd)
  );

  // command decode and registers
  uart_regs uart_regs_inst (
    .sys_clk      (sys_clk),
    .arst_n       (arst_n),
    .rx_data      (rx_data),
    .rx_strobe    (rx_strobe),
    .rx_frame_err (rx_frame_err),
    .tx_busy      (tx_busy),
    .baud_div     (baud_div),
    .tx_data      (tx_data),
    .tx_start     (tx_start)
  );

endmodule

`default_nettype wire

/* uart_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_link_settings.svh"

module uart_regs import uart_cmd_pkg::*; (
  input  wire                    sys_clk,
  input  wire                    arst_n,
  input  wire [7:0]              rx_data,
  input  wire                    rx_strobe,
  input  wire                    rx_frame_err,
  input  wire                    tx_busy,
  output logic [`BAUD_DIV_W-1:0] baud_div,   // shared by rx and tx
  output logic [7:0]             tx_data,    // read response byte
  output logic                   tx_start
);

  dec_state_e             dec_state;
  cmd_op_e                op_q;       // opcode of current frame
  logic [7:0]             addr_q;     // write target
  logic [7:0]             scratch0;
  logic [7:0]             scratch1;
  logic [7:0]             err_cnt;    // saturating
  logic [`BAUD_DIV_W-1:0] div_new;
  logic [7:0]             rd_value;
  logic                   op_known;
  logic                   addr_bad;
  logic                   rd_fire;
  logic                   wr_fire;
  logic                   err_event;

  //**************************************************
  // frame decode
  //**************************************************

  assign op_known = (rx_data == CMD_WRITE) || (rx_data == CMD_READ);
  assign addr_bad = (rx_data > `REG_ERR_CNT);
  assign rd_fire  = rx_strobe && dec_state == DEC_ADDR && !addr_bad &&
                    op_q == CMD_READ && !tx_busy;
  assign wr_fire  = rx_strobe && dec_state == DEC_DATA;

  // one source per cycle at most, strobe and frame error never coincide
  assign err_event = rx_frame_err ||
                     (rx_strobe && dec_state == DEC_OP && !op_known) ||
                     (rx_strobe && dec_state == DEC_ADDR && addr_bad) ||
                     (rx_strobe && dec_state == DEC_ADDR && !addr_bad &&
                      op_q == CMD_READ && tx_busy);  // dropped read

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_state <= DEC_OP;
      op_q      <= CMD_WRITE;
      addr_q    <= 8'd0;
      tx_start  <= 1'b0;
    end else begin
      tx_start <= rd_fire;                 // pulse, one cycle after addr strobe
      if (rx_frame_err) begin
        dec_state <= DEC_OP;               // byte lost, resync on opcode
      end else if (rx_strobe) begin
        case (dec_state)
          DEC_OP: begin
            if (op_known) begin
              op_q      <= cmd_op_e'(rx_data);
              dec_state <= DEC_ADDR;
            end
          end
          DEC_ADDR: begin
            addr_q <= rx_data;
            if (!addr_bad && op_q == CMD_WRITE) dec_state <= DEC_DATA;
            else dec_state <= DEC_OP;      // read done or bad addr
          end
          default: dec_state <= DEC_OP;    // data byte ends the write
        endcase
      end
    end
  end

  //**************************************************
  // register file
  //**************************************************

  // divisor with one byte replaced
  always_comb begin
    case (addr_q)
      `REG_DIV_LO: div_new = {baud_div[15:8], rx_data};
      `REG_DIV_HI: div_new = {rx_data, baud_div[7:0]};
      default:     div_new = baud_div;
    endcase
  end

  // read mux, address is the byte in flight
  always_comb begin
    case (rx_data)
      `REG_DIV_LO:   rd_value = baud_div[7:0];
      `REG_DIV_HI:   rd_value = baud_div[15:8];
      `REG_SCRATCH0: rd_value = scratch0;
      `REG_SCRATCH1: rd_value = scratch1;
      default:       rd_value = err_cnt;
    endcase
  end

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      baud_div <= `BAUD_DIV_RST;
      scratch0 <= 8'd0;
      scratch1 <= 8'd0;
      err_cnt  <= 8'd0;
    end else begin
      if (wr_fire) begin
        case (addr_q)
          `REG_DIV_LO, `REG_DIV_HI: if (div_new >= `BAUD_DIV_MIN) baud_div <= div_new;
          `REG_SCRATCH0: scratch0 <= rx_data;
          `REG_SCRATCH1: scratch1 <= rx_data;
          default: ;
        endcase
      end
      if (wr_fire && addr_q == `REG_ERR_CNT)
        err_cnt <= 8'd0;                   // write clears
      else if (err_event && err_cnt != 8'hff)
        err_cnt <= err_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_fire) tx_data <= rd_value;      // valid with tx_start
  end

  a_div_min: assert property (@(posedge sys_clk) disable iff (!arst_n)
    baud_div >= `BAUD_DIV_MIN)
    else $error("uart_regs divisor below minimum");

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_link_settings.svh"

module uart_rx import uart_line_pkg::*; (
  input  wire                   sys_clk,
  input  wire                   arst_n,
  input  wire                   uart_rxd,      // async serial in
  input  wire [`BAUD_DIV_W-1:0] baud_div,      // cycles per bit
  output logic [7:0]            rx_data,       // held until next strobe
  output logic                  rx_strobe,     // one cycle, byte good
  output logic                  rx_frame_err   // one cycle, stop bit low
);

  logic                   rxd_meta;
  logic                   rxd_sync;
  logic                   rxd_prev;
  logic                   start_edge;
  rx_state_e              rx_state;
  logic [`BAUD_DIV_W-1:0] bit_cnt;   // cycles inside current bit
  logic [2:0]             bit_idx;   // data bit number
  logic [7:0]             rx_shift;
  logic                   mid_bit;
  logic                   end_bit;

  //**************************************************
  // sync and edge detect
  //**************************************************

  // high idle line after reset, no false edge
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= uart_rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign start_edge = rxd_prev & ~rxd_sync;  // high then low
  assign mid_bit    = (bit_cnt == (baud_div >> 1));
  // >= so a shrinking divisor cannot strand the counter
  assign end_bit    = (bit_cnt >= baud_div - 1'b1);

  //**************************************************
  // frame FSM
  //**************************************************

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_state     <= RX_IDLE;
      bit_cnt      <= '0;
      bit_idx      <= 3'd0;
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
      if (rx_state == RX_IDLE || end_bit)
        bit_cnt <= '0;
      else
        bit_cnt <= bit_cnt + 1'b1;
      case (rx_state)
        RX_IDLE: if (start_edge) rx_state <= RX_START;
        RX_START: begin
          if (mid_bit && rxd_sync) begin
            rx_state <= RX_IDLE;           // glitch, line back high
          end else if (end_bit) begin
            rx_state <= RX_DATA;
            bit_idx  <= 3'd0;
          end
        end
        RX_DATA: begin
          if (end_bit) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) rx_state <= RX_STOP;
          end
        end
        RX_STOP: begin
          // done at mid stop, next start edge can follow
          if (mid_bit) begin
            rx_state     <= RX_IDLE;
            rx_strobe    <= rxd_sync;
            rx_frame_err <= ~rxd_sync;
          end
        end
        default: rx_state <= RX_IDLE;
      endcase
    end
  end

  // data path
  always_ff @(posedge sys_clk) begin
    if (rx_state == RX_DATA && mid_bit)
      rx_shift <= {rxd_sync, rx_shift[7:1]};  // lsb arrives first
    if (rx_state == RX_STOP && mid_bit && rxd_sync)
      rx_data <= rx_shift;
  end

  a_cnt_in_range: assert property (@(posedge sys_clk) disable iff (!arst_n)
    (rx_state != RX_IDLE) |-> (bit_cnt < baud_div))
    else $error("uart_rx bit counter past divisor");

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_link_settings.svh"

module uart_tx import uart_line_pkg::*; (
  input  wire                   sys_clk,
  input  wire                   arst_n,
  input  wire [`BAUD_DIV_W-1:0] baud_div,
  input  wire [7:0]             tx_data,   // taken on tx_start
  input  wire                   tx_start,  // one cycle pulse
  output logic                  tx_busy,   // high through stop bit
  output logic                  uart_txd   // serial out, idle high
);

  tx_state_e              tx_state;
  logic [`BAUD_DIV_W-1:0] bit_cnt;
  logic [2:0]             bit_idx;
  logic [7:0]             tx_shift;  // bit 0 is next data bit
  logic                   end_bit;

  assign end_bit = (bit_cnt >= baud_div - 1'b1);

  //**************************************************
  // serializer FSM
  //**************************************************

  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= TX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= 3'd0;
      tx_busy  <= 1'b0;
      uart_txd <= 1'b1;
    end else begin
      if (tx_state == TX_IDLE || end_bit)
        bit_cnt <= '0;
      else
        bit_cnt <= bit_cnt + 1'b1;
      case (tx_state)
        TX_IDLE: begin
          if (tx_start) begin
            tx_state <= TX_START;
            tx_busy  <= 1'b1;
            uart_txd <= 1'b0;             // start bit
          end
        end
        TX_START: begin
          if (end_bit) begin
            tx_state <= TX_DATA;
            bit_idx  <= 3'd0;
            uart_txd <= tx_shift[0];
          end
        end
        TX_DATA: begin
          if (end_bit) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              tx_state <= TX_STOP;
              uart_txd <= 1'b1;           // stop bit
            end else begin
              uart_txd <= tx_shift[1];    // shift lands same edge
            end
          end
        end
        TX_STOP: begin
          if (end_bit) begin
            tx_state <= TX_IDLE;
            tx_busy  <= 1'b0;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  // byte latch and shift
  always_ff @(posedge sys_clk) begin
    if (tx_state == TX_IDLE && tx_start)
      tx_shift <= tx_data;
    else if (tx_state == TX_DATA && end_bit)
      tx_shift <= tx_shift >> 1;
  end

  a_no_start_busy: assert property (@(posedge sys_clk) disable iff (!arst_n)
    tx_start |-> !tx_busy)
    else $error("uart_tx start while busy");

  a_idle_high: assert property (@(posedge sys_clk) disable iff (!arst_n)
    (tx_state == TX_IDLE) |-> uart_txd)
    else $error("uart_tx line low in idle");

endmodule

`default_nettype wire
